// ==== hdl/pce_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width, set count and credit macros for the cache engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PCE_PARAMS_SVH
`define PCE_PARAMS_SVH

// Address and data widths
`define PCE_PADDR_W 40
`define PCE_DWORD_W 64
`define PCE_BLOCK_W 128

// Cache geometry of two ways per set
`define PCE_SETS 256
`define PCE_INDEX_W 8
`define PCE_BLOCK_OFFSET_W 4
`define PCE_TAG_W 28

// Outstanding L1.5 requests
`define PCE_MAX_CREDITS 4
`define PCE_CREDIT_W 3

`endif

// ==== hdl/pce_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the cache side and the L1.5 side of the engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pce_params.svh"

package pce_pkg;

  typedef logic [`PCE_PADDR_W-1:0]  paddr_t;
  typedef logic [`PCE_DWORD_W-1:0]  dword_t;
  typedef logic [`PCE_BLOCK_W-1:0]  block_t;
  typedef logic [`PCE_INDEX_W-1:0]  index_t;
  typedef logic                     way_t;
  typedef logic [`PCE_TAG_W-1:0]    tag_t;
  typedef logic [`PCE_CREDIT_W-1:0] credit_t;

  typedef enum logic [2:0] {e_miss_load, e_miss_store, e_uc_load, e_uc_store, e_wt_store}
    cache_msg_e;
  typedef enum logic [1:0] {e_size_1B, e_size_2B, e_size_4B, e_size_8B} req_size_e;

  typedef enum logic [1:0] {e_load_req, e_store_req} l15_rqtype_e;
  typedef enum logic [2:0] {e_l15_size_1B, e_l15_size_2B, e_l15_size_4B, e_l15_size_8B,
    e_l15_size_16B} l15_size_e;
  typedef enum logic [2:0] {e_load_ret, e_st_ack, e_evict_req, e_int_ret} l15_rtntype_e;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_set_tag, e_tag_invalidate} tag_opcode_e;
  typedef enum logic {e_data_write, e_data_uncached} data_opcode_e;
  typedef enum logic [1:0] {e_coh_i, e_coh_m} coh_state_e;

  // Work handed from the state machine to the datapath
  typedef enum logic [1:0] {e_req_store_nc, e_req_store_wt, e_req_miss, e_req_uc_load}
    req_op_e;
  typedef enum logic [2:0] {e_ret_none, e_ret_init, e_ret_clear, e_ret_fill, e_ret_uncached}
    ret_op_e;

  typedef enum logic [2:0] {e_reset, e_clear, e_ready, e_send_req, e_uc_read_wait,
    e_read_wait} pce_state_e;

  typedef struct packed {
    cache_msg_e msg_type;
    req_size_e  size;
    paddr_t     addr;
    dword_t     data;
  } cache_req_s;

  typedef struct packed {
    way_t repl_way;
  } cache_meta_s;

  typedef struct packed {
    l15_rqtype_e rqtype;
    logic        nc;
    l15_size_e   size;
    paddr_t      address;
    dword_t      data;
    logic [1:0]  l1rplway;
  } l15_req_s;

  typedef struct packed {
    l15_rtntype_e rtntype;
    logic         noncacheable;
    dword_t       data_0;
    dword_t       data_1;
    logic         inval_dcache_inval;
    logic [1:0]   inval_way;
    // Address bits 15:4
    logic [11:0]  inval_addr;
  } l15_ret_s;

  typedef struct packed {
    data_opcode_e opcode;
    index_t       index;
    way_t         way_id;
    block_t       data;
  } data_mem_pkt_s;

  typedef struct packed {
    tag_opcode_e opcode;
    index_t      index;
    way_t        way_id;
    tag_t        tag;
    coh_state_e  state;
  } tag_mem_pkt_s;

  // L1.5 is big endian, the L1 is little endian
  function automatic dword_t reverse_bytes(dword_t d);
    dword_t r;
    for (int i = 0; i < `PCE_DWORD_W/8; i++) begin
      r[8*i +: 8] = d[8*(`PCE_DWORD_W/8-1-i) +: 8];
    end
    return r;
  endfunction

endpackage

// ==== hdl/pce_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine state machine and tag sweep index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "pce_params.svh"

module pce_fsm (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                cache_req_v_i,
  input  pce_pkg::cache_msg_e cache_msg_i,
  input  logic                pce_l15_req_ready_i,
  input  logic                ret_done_i,
  output logic                cache_req_ready_o,
  output logic                cache_req_complete_o,
  output logic                capture_o,
  output logic                req_fire_o,
  output pce_pkg::req_op_e    req_op_o,
  output pce_pkg::ret_op_e    ret_op_o,
  output pce_pkg::index_t     sweep_index_o
);

  import pce_pkg::*;

  pce_state_e state_r;
  pce_state_e state_n;
  req_op_e    op_r;
  req_op_e    op_n;
  index_t     index_r;
  logic       index_up;
  logic       accept;
  logic       is_store;

  assign accept   = cache_req_v_i & pce_l15_req_ready_i;
  assign is_store = (cache_msg_i == e_uc_store) | (cache_msg_i == e_wt_store);

  assign sweep_index_o = index_r;

  always_comb begin
    state_n              = state_r;
    op_n                 = op_r;
    index_up             = 1'b0;
    cache_req_ready_o    = 1'b0;
    cache_req_complete_o = 1'b0;
    capture_o            = 1'b0;
    req_fire_o           = 1'b0;
    req_op_o             = op_r;
    ret_op_o             = e_ret_none;

    case (state_r)
      e_reset: begin
        // Wait for the L1.5 to come out of reset
        ret_op_o = e_ret_init;
        if (ret_done_i) begin
          state_n = e_clear;
        end
      end
      e_clear: begin
        ret_op_o = e_ret_clear;
        index_up = ret_done_i;
        if (ret_done_i && (index_r == index_t'(`PCE_SETS-1))) begin
          cache_req_complete_o = 1'b1;
          state_n              = e_ready;
        end
      end
      e_ready: begin
        cache_req_ready_o = pce_l15_req_ready_i;
        if (accept && is_store) begin
          // Stores go straight through to the L1.5
          req_fire_o = 1'b1;
          req_op_o   = (cache_msg_i == e_uc_store) ? e_req_store_nc : e_req_store_wt;
        end else if (accept) begin
          capture_o = 1'b1;
          op_n      = (cache_msg_i == e_uc_load) ? e_req_uc_load : e_req_miss;
          state_n   = e_send_req;
        end
      end
      e_send_req: begin
        req_fire_o = pce_l15_req_ready_i;
        if (pce_l15_req_ready_i) begin
          state_n = (op_r == e_req_uc_load) ? e_uc_read_wait : e_read_wait;
        end
      end
      e_uc_read_wait: begin
        ret_op_o = e_ret_uncached;
        if (ret_done_i) begin
          state_n = e_ready;
        end
      end
      e_read_wait: begin
        ret_op_o = e_ret_fill;
        if (ret_done_i) begin
          state_n = e_ready;
        end
      end
      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      op_r    <= e_req_miss;
      index_r <= '0;
    end else begin
      state_r <= state_n;
      op_r    <= op_n;
      if (index_up) begin
        index_r <= index_r + index_t'(1);
      end
    end
  end

endmodule

// ==== hdl/pce_credit_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outstanding L1.5 request counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "pce_params.svh"

module pce_credit_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  logic ret_yumi_i,
  output logic credits_full_o,
  output logic credits_empty_o
);

  import pce_pkg::*;

  credit_t count_r;
  logic    dec;

  // Returns that carry no credit, like the start-up interrupt, never go below zero
  assign dec = ret_yumi_i & ((count_r != '0) | req_v_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else begin
      count_r <= count_r + credit_t'(req_v_i) - credit_t'(dec);
    end
  end

  assign credits_full_o  = (count_r == credit_t'(`PCE_MAX_CREDITS));
  assign credits_empty_o = (count_r == '0);

endmodule

// ==== hdl/pce_req_path.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Held load request and L1.5 request encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pce_req_path (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  pce_pkg::cache_req_s  cache_req_i,
  input  logic                 capture_i,
  input  pce_pkg::cache_meta_s cache_meta_i,
  input  logic                 cache_meta_v_i,
  input  logic                 req_fire_i,
  input  pce_pkg::req_op_e     req_op_i,
  output pce_pkg::l15_req_s    pce_l15_req_o,
  output logic                 pce_l15_req_v_o,
  output pce_pkg::paddr_t      held_addr_o,
  output pce_pkg::way_t        held_way_o
);

  import pce_pkg::*;

  cache_req_s held_req_r;
  way_t       way_r;
  way_t       way;

  function automatic l15_size_e map_size(req_size_e s);
    l15_size_e m;
    case (s)
      e_size_1B: m = e_l15_size_1B;
      e_size_2B: m = e_l15_size_2B;
      e_size_4B: m = e_l15_size_4B;
      default:   m = e_l15_size_8B;
    endcase
    return m;
  endfunction

  // Swap into big-endian order and repeat across the double word
  function automatic dword_t store_data(req_size_e s, dword_t d);
    dword_t r;
    dword_t o;
    r = reverse_bytes(d);
    case (s)
      e_size_1B: o = {8{r[63:56]}};
      e_size_2B: o = {4{r[63:48]}};
      e_size_4B: o = {2{r[63:32]}};
      default:   o = r;
    endcase
    return o;
  endfunction

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      held_req_r <= cache_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      way_r <= 1'b0;
    end else if (cache_meta_v_i) begin
      way_r <= cache_meta_i.repl_way;
    end
  end

  // Metadata may land in the same cycle as the request
  assign way = cache_meta_v_i ? cache_meta_i.repl_way : way_r;

  assign held_addr_o = held_req_r.addr;
  assign held_way_o  = way;

  always_comb begin
    pce_l15_req_o = '0;
    case (req_op_i)
      e_req_store_nc, e_req_store_wt: begin
        pce_l15_req_o.rqtype  = e_store_req;
        pce_l15_req_o.nc      = (req_op_i == e_req_store_nc);
        pce_l15_req_o.size    = map_size(cache_req_i.size);
        pce_l15_req_o.address = cache_req_i.addr;
        pce_l15_req_o.data    = store_data(cache_req_i.size, cache_req_i.data);
      end
      e_req_miss: begin
        pce_l15_req_o.rqtype   = e_load_req;
        pce_l15_req_o.nc       = 1'b0;
        pce_l15_req_o.size     = e_l15_size_8B;
        pce_l15_req_o.address  = held_req_r.addr;
        pce_l15_req_o.l1rplway = {held_req_r.addr[11], way};
      end
      default: begin
        pce_l15_req_o.rqtype   = e_load_req;
        pce_l15_req_o.nc       = 1'b1;
        pce_l15_req_o.size     = map_size(held_req_r.size);
        pce_l15_req_o.address  = held_req_r.addr;
        pce_l15_req_o.l1rplway = {held_req_r.addr[11], way};
      end
    endcase
  end

  assign pce_l15_req_v_o = req_fire_i;

endmodule

// ==== hdl/pce_return_handler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1.5 return decoder and cache memory packet builder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "pce_params.svh"

module pce_return_handler (
  input  logic                   l15_pce_ret_v_i,
  input  pce_pkg::l15_ret_s      l15_pce_ret_i,
  input  pce_pkg::ret_op_e       ret_op_i,
  input  pce_pkg::index_t        sweep_index_i,
  input  pce_pkg::paddr_t        held_addr_i,
  input  pce_pkg::way_t          held_way_i,
  input  logic                   data_mem_pkt_yumi_i,
  input  logic                   tag_mem_pkt_yumi_i,
  output logic                   l15_pce_ret_yumi_o,
  output logic                   ret_done_o,
  output pce_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                   data_mem_pkt_v_o,
  output pce_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                   tag_mem_pkt_v_o
);

  import pce_pkg::*;

  logic   int_v;
  logic   st_ack_v;
  logic   fill_v;
  logic   uc_v;
  logic   inval_v;
  index_t held_index;
  tag_t   held_tag;

  assign int_v    = l15_pce_ret_v_i & (l15_pce_ret_i.rtntype == e_int_ret);
  assign st_ack_v = l15_pce_ret_v_i & (l15_pce_ret_i.rtntype == e_st_ack);
  assign fill_v   = l15_pce_ret_v_i & (l15_pce_ret_i.rtntype == e_load_ret)
                    & ~l15_pce_ret_i.noncacheable;
  assign uc_v     = l15_pce_ret_v_i & (l15_pce_ret_i.rtntype == e_load_ret)
                    & l15_pce_ret_i.noncacheable;
  // Evicts wait until the tag sweep is over
  assign inval_v  = l15_pce_ret_v_i & (l15_pce_ret_i.rtntype == e_evict_req)
                    & l15_pce_ret_i.inval_dcache_inval & (ret_op_i != e_ret_clear);

  assign held_index = held_addr_i[`PCE_BLOCK_OFFSET_W +: `PCE_INDEX_W];
  assign held_tag   = held_addr_i[`PCE_BLOCK_OFFSET_W+`PCE_INDEX_W +: `PCE_TAG_W];

  always_comb begin
    data_mem_pkt_o     = '0;
    data_mem_pkt_v_o   = 1'b0;
    tag_mem_pkt_o      = '0;
    tag_mem_pkt_v_o    = 1'b0;
    l15_pce_ret_yumi_o = 1'b0;
    ret_done_o         = 1'b0;

    case (ret_op_i)
      e_ret_init: begin
        l15_pce_ret_yumi_o = int_v;
        ret_done_o         = int_v;
      end
      e_ret_clear: begin
        tag_mem_pkt_o.opcode = e_tag_set_clear;
        tag_mem_pkt_o.index  = sweep_index_i;
        tag_mem_pkt_v_o      = 1'b1;
        ret_done_o           = tag_mem_pkt_yumi_i;
      end
      e_ret_fill: begin
        data_mem_pkt_o.opcode = e_data_write;
        data_mem_pkt_o.index  = held_index;
        data_mem_pkt_o.way_id = held_way_i;
        data_mem_pkt_o.data   = {reverse_bytes(l15_pce_ret_i.data_1),
                                 reverse_bytes(l15_pce_ret_i.data_0)};
        data_mem_pkt_v_o      = fill_v;
        tag_mem_pkt_o.opcode  = e_tag_set_tag;
        tag_mem_pkt_o.index   = held_index;
        tag_mem_pkt_o.way_id  = held_way_i;
        tag_mem_pkt_o.tag     = held_tag;
        tag_mem_pkt_o.state   = e_coh_m;
        tag_mem_pkt_v_o       = fill_v;
        // Both memories must take their packet together
        l15_pce_ret_yumi_o    = fill_v & data_mem_pkt_yumi_i & tag_mem_pkt_yumi_i;
        ret_done_o            = l15_pce_ret_yumi_o;
      end
      e_ret_uncached: begin
        data_mem_pkt_o.opcode = e_data_uncached;
        data_mem_pkt_o.data   = {{`PCE_DWORD_W{1'b0}}, reverse_bytes(l15_pce_ret_i.data_0)};
        data_mem_pkt_v_o      = uc_v;
        l15_pce_ret_yumi_o    = uc_v & data_mem_pkt_yumi_i;
        ret_done_o            = l15_pce_ret_yumi_o;
      end
      default: begin
        ret_done_o = 1'b0;
      end
    endcase

    if (st_ack_v) begin
      l15_pce_ret_yumi_o = 1'b1;
    end

    // Invalidates own the tag port whenever they show up
    if (inval_v) begin
      tag_mem_pkt_o        = '0;
      tag_mem_pkt_o.opcode = e_tag_invalidate;
      tag_mem_pkt_o.index  = {l15_pce_ret_i.inval_way[1], l15_pce_ret_i.inval_addr[6:0]};
      tag_mem_pkt_o.way_id = l15_pce_ret_i.inval_way[0];
      tag_mem_pkt_v_o      = 1'b1;
      l15_pce_ret_yumi_o   = tag_mem_pkt_yumi_i;
    end
  end

endmodule

// ==== hdl/pce_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-Mesh cache engine top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pce_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pce_pkg::cache_req_s    cache_req_i,
  input  logic                   cache_req_v_i,
  output logic                   cache_req_ready_o,
  input  pce_pkg::cache_meta_s   cache_meta_i,
  input  logic                   cache_meta_v_i,
  output logic                   cache_req_complete_o,
  output pce_pkg::l15_req_s      pce_l15_req_o,
  output logic                   pce_l15_req_v_o,
  input  logic                   pce_l15_req_ready_i,
  input  logic                   l15_pce_ret_v_i,
  input  pce_pkg::l15_ret_s      l15_pce_ret_i,
  output logic                   l15_pce_ret_yumi_o,
  output pce_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                   data_mem_pkt_v_o,
  input  logic                   data_mem_pkt_yumi_i,
  output pce_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                   tag_mem_pkt_v_o,
  input  logic                   tag_mem_pkt_yumi_i,
  output logic                   credits_full_o,
  output logic                   credits_empty_o
);

  import pce_pkg::*;

  logic    capture;
  logic    req_fire;
  req_op_e req_op;
  ret_op_e ret_op;
  index_t  sweep_index;
  logic    ret_done;
  paddr_t  held_addr;
  way_t    held_way;

  pce_fsm fsm_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cache_req_v_i       (cache_req_v_i),
    .cache_msg_i         (cache_req_i.msg_type),
    .pce_l15_req_ready_i (pce_l15_req_ready_i),
    .ret_done_i          (ret_done),
    .cache_req_ready_o   (cache_req_ready_o),
    .cache_req_complete_o(cache_req_complete_o),
    .capture_o           (capture),
    .req_fire_o          (req_fire),
    .req_op_o            (req_op),
    .ret_op_o            (ret_op),
    .sweep_index_o       (sweep_index)
  );

  pce_req_path req_path_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cache_req_i    (cache_req_i),
    .capture_i      (capture),
    .cache_meta_i   (cache_meta_i),
    .cache_meta_v_i (cache_meta_v_i),
    .req_fire_i     (req_fire),
    .req_op_i       (req_op),
    .pce_l15_req_o  (pce_l15_req_o),
    .pce_l15_req_v_o(pce_l15_req_v_o),
    .held_addr_o    (held_addr),
    .held_way_o     (held_way)
  );

  pce_return_handler return_handler_i (
    .l15_pce_ret_v_i    (l15_pce_ret_v_i),
    .l15_pce_ret_i      (l15_pce_ret_i),
    .ret_op_i           (ret_op),
    .sweep_index_i      (sweep_index),
    .held_addr_i        (held_addr),
    .held_way_i         (held_way),
    .data_mem_pkt_yumi_i(data_mem_pkt_yumi_i),
    .tag_mem_pkt_yumi_i (tag_mem_pkt_yumi_i),
    .l15_pce_ret_yumi_o (l15_pce_ret_yumi_o),
    .ret_done_o         (ret_done),
    .data_mem_pkt_o     (data_mem_pkt_o),
    .data_mem_pkt_v_o   (data_mem_pkt_v_o),
    .tag_mem_pkt_o      (tag_mem_pkt_o),
    .tag_mem_pkt_v_o    (tag_mem_pkt_v_o)
  );

  pce_credit_counter credit_counter_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (pce_l15_req_v_o),
    .ret_yumi_i     (l15_pce_ret_yumi_o),
    .credits_full_o (credits_full_o),
    .credits_empty_o(credits_empty_o)
  );

endmodule

// ==== verif/pce_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and synchronous reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pce_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns/2) clk_o = ~clk_o;
  end

  // Release just after an edge so the DUT never sees it change on one
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

// ==== verif/pce_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache engine testbench with reference model and monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "pce_params.svh"

module pce_tb;

  import pce_pkg::*;

  // Sweep plus about 60 transactions and a margin for back-pressure
  localparam int max_cycles = 3000;

  logic          clk_i;
  logic          reset_i;
  cache_req_s    cache_req_i;
  logic          cache_req_v_i;
  logic          cache_req_ready_o;
  cache_meta_s   cache_meta_i;
  logic          cache_meta_v_i;
  logic          cache_req_complete_o;
  l15_req_s      pce_l15_req_o;
  logic          pce_l15_req_v_o;
  logic          pce_l15_req_ready_i;
  logic          l15_pce_ret_v_i;
  l15_ret_s      l15_pce_ret_i;
  logic          l15_pce_ret_yumi_o;
  data_mem_pkt_s data_mem_pkt_o;
  logic          data_mem_pkt_v_o;
  logic          data_mem_pkt_yumi_i;
  tag_mem_pkt_s  tag_mem_pkt_o;
  logic          tag_mem_pkt_v_o;
  logic          tag_mem_pkt_yumi_i;
  logic          credits_full_o;
  logic          credits_empty_o;

  l15_req_s      req_q[$];
  data_mem_pkt_s data_q[$];
  tag_mem_pkt_s  tag_q[$];
  int            reqs_seen;
  int            clears_seen;
  int            credit_cnt;
  int            cycle_cnt;
  // High while the engine should accept cache requests
  logic          engine_idle;

  pce_clock_gen clk_gen_i (
    .clk_o  (clk_i),
    .reset_o(reset_i)
  );

  pce_top dut_i (.*);

  task automatic fail_run;
    $display("Done: errors found");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_l15_req(input l15_req_s exp, input l15_req_s act);
    if (act !== exp) begin
      $display("MISMATCH time %0t pce_l15_req_o expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_data_pkt(input data_mem_pkt_s exp, input data_mem_pkt_s act);
    if (act !== exp) begin
      $display("MISMATCH time %0t data_mem_pkt_o expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_tag_pkt(input tag_mem_pkt_s exp, input tag_mem_pkt_s act);
    if (act !== exp) begin
      $display("MISMATCH time %0t tag_mem_pkt_o expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time %0t %s expected %b actual %b", $time, name, exp, act);
      fail_run();
    end
  endtask

  // Little-endian double word to L1.5 byte order
  function automatic dword_t be_swap(dword_t d);
    return {<<8{d}};
  endfunction

  // Low bytes of the store in big-endian order, repeated over the double word
  function automatic l15_req_s store_req_ref(cache_msg_e msg, req_size_e size, paddr_t addr,
                                             dword_t data);
    l15_req_s r;
    int       n;
    n = 1 << int'(size);
    r = '0;
    r.rqtype  = e_store_req;
    r.nc      = (msg == e_uc_store);
    r.size    = l15_size_e'({1'b0, size});
    r.address = addr;
    for (int p = 0; p < 8; p++) begin
      r.data[8*(7-p) +: 8] = data[8*(p % n) +: 8];
    end
    return r;
  endfunction

  function automatic l15_req_s load_req_ref(cache_msg_e msg, req_size_e size, paddr_t addr,
                                            way_t way);
    l15_req_s r;
    r = '0;
    r.rqtype  = e_load_req;
    r.nc      = (msg == e_uc_load);
    if (msg == e_uc_load) begin
      r.size = l15_size_e'({1'b0, size});
    end else begin
      r.size = e_l15_size_8B;
    end
    r.address  = addr;
    r.l1rplway = {addr[11], way};
    return r;
  endfunction

  function automatic data_mem_pkt_s fill_data_ref(paddr_t addr, way_t way, dword_t d0,
                                                  dword_t d1);
    data_mem_pkt_s p;
    p = '0;
    p.opcode = e_data_write;
    p.index  = addr[`PCE_BLOCK_OFFSET_W +: `PCE_INDEX_W];
    p.way_id = way;
    p.data   = {be_swap(d1), be_swap(d0)};
    return p;
  endfunction

  function automatic tag_mem_pkt_s fill_tag_ref(paddr_t addr, way_t way);
    tag_mem_pkt_s p;
    p = '0;
    p.opcode = e_tag_set_tag;
    p.index  = addr[`PCE_BLOCK_OFFSET_W +: `PCE_INDEX_W];
    p.way_id = way;
    p.tag    = addr[`PCE_BLOCK_OFFSET_W+`PCE_INDEX_W +: `PCE_TAG_W];
    p.state  = e_coh_m;
    return p;
  endfunction

  function automatic data_mem_pkt_s uc_data_ref(dword_t d0);
    data_mem_pkt_s p;
    p = '0;
    p.opcode = e_data_uncached;
    p.data   = block_t'(be_swap(d0));
    return p;
  endfunction

  function automatic tag_mem_pkt_s inval_tag_ref(logic [1:0] way2, logic [11:0] addr12);
    tag_mem_pkt_s p;
    p = '0;
    p.opcode = e_tag_invalidate;
    p.index  = {way2[1], addr12[6:0]};
    p.way_id = way2[0];
    return p;
  endfunction

  function automatic tag_mem_pkt_s clear_tag_ref(index_t i);
    tag_mem_pkt_s p;
    p = '0;
    p.opcode = e_tag_set_clear;
    p.index  = i;
    return p;
  endfunction

  // Whether the return on the bus is consumed, given the memory yumis
  function automatic logic ret_yumi_ref(logic v, l15_ret_s ret, logic d_yumi, logic t_yumi);
    logic y;
    y = 1'b0;
    if (v) begin
      case (ret.rtntype)
        e_st_ack, e_int_ret: y = 1'b1;
        e_evict_req:         y = t_yumi;
        default:             y = ret.noncacheable ? d_yumi : (d_yumi && t_yumi);
      endcase
    end
    return y;
  endfunction

  task automatic next_cycle;
    @(posedge clk_i);
    #1;
  endtask

  task automatic offer_req(input cache_req_s req, input logic meta_v, input way_t way);
    cache_req_i             = req;
    cache_req_v_i           = 1'b1;
    cache_meta_v_i          = meta_v;
    cache_meta_i.repl_way   = way;
    do @(negedge clk_i); while (!cache_req_ready_o);
    next_cycle();
    cache_req_v_i  = 1'b0;
    cache_meta_v_i = 1'b0;
  endtask

  // Hold the return until the engine consumes it
  task automatic send_ret(input l15_ret_s ret);
    l15_pce_ret_i   = ret;
    l15_pce_ret_v_i = 1'b1;
    do @(negedge clk_i); while (!l15_pce_ret_yumi_o);
    next_cycle();
    l15_pce_ret_v_i = 1'b0;
  endtask

  task automatic send_store;
    cache_req_s  req;
    logic [31:0] r;
    r = $urandom;
    req.msg_type = r[0] ? e_uc_store : e_wt_store;
    req.size     = req_size_e'(r[2:1]);
    req.addr     = {r[15:8], $urandom};
    req.data     = {$urandom, $urandom};
    req_q.push_back(store_req_ref(req.msg_type, req.size, req.addr, req.data));
    offer_req(req, 1'b0, 1'b0);
  endtask

  task automatic send_evict;
    l15_ret_s    ret;
    logic [31:0] r;
    r = $urandom;
    ret = '0;
    ret.rtntype            = e_evict_req;
    ret.inval_dcache_inval = 1'b1;
    ret.inval_way          = r[1:0];
    ret.inval_addr         = r[13:2];
    tag_q.push_back(inval_tag_ref(ret.inval_way, ret.inval_addr));
    send_ret(ret);
  endtask

  task automatic run_load(input logic uc, input logic with_evict);
    cache_req_s  req;
    l15_ret_s    ret;
    way_t        way;
    int          target;
    logic [31:0] r;
    r = $urandom;
    req.msg_type = uc ? e_uc_load : e_miss_load;
    req.size     = req_size_e'(r[1:0]);
    req.addr     = {r[15:8], $urandom};
    req.data     = '0;
    way          = r[16];
    req_q.push_back(load_req_ref(req.msg_type, req.size, req.addr, way));
    target = reqs_seen + 1;
    offer_req(req, 1'b1, way);
    engine_idle = 1'b0;
    while (reqs_seen < target) begin
      next_cycle();
    end
    if (with_evict) begin
      send_evict();
    end
    ret = '0;
    ret.rtntype      = e_load_ret;
    ret.noncacheable = uc;
    ret.data_0       = {$urandom, $urandom};
    ret.data_1       = {$urandom, $urandom};
    if (uc) begin
      data_q.push_back(uc_data_ref(ret.data_0));
    end else begin
      data_q.push_back(fill_data_ref(req.addr, way, ret.data_0, ret.data_1));
      tag_q.push_back(fill_tag_ref(req.addr, way));
    end
    send_ret(ret);
    engine_idle = 1'b1;
  endtask

  // Random back-pressure from the L1.5 and both cache memories
  initial begin
    logic [31:0] r;
    pce_l15_req_ready_i = 1'b0;
    data_mem_pkt_yumi_i = 1'b0;
    tag_mem_pkt_yumi_i  = 1'b0;
    forever begin
      next_cycle();
      r = $urandom;
      pce_l15_req_ready_i = (r[2:0] != 3'b000);
      data_mem_pkt_yumi_i = (r[4:3] != 2'b00);
      tag_mem_pkt_yumi_i  = (r[6:5] != 2'b00);
    end
  end

  // Every transfer is matched against the expected queues
  always @(negedge clk_i) begin
    logic pkt_take;
    // A fill writes both memories in the same cycle or not at all
    pkt_take = !(data_mem_pkt_v_o && tag_mem_pkt_v_o) ||
               (data_mem_pkt_yumi_i && tag_mem_pkt_yumi_i);
    if (!reset_i) begin
      check_flag("credits_empty_o", credit_cnt == 0, credits_empty_o);
      check_flag("credits_full_o", credit_cnt == `PCE_MAX_CREDITS, credits_full_o);
      check_flag("cache_req_ready_o", engine_idle && pce_l15_req_ready_i,
                 cache_req_ready_o);
      check_flag("l15_pce_ret_yumi_o", ret_yumi_ref(l15_pce_ret_v_i, l15_pce_ret_i,
                 data_mem_pkt_yumi_i, tag_mem_pkt_yumi_i), l15_pce_ret_yumi_o);
      check_flag("cache_req_complete_o", tag_mem_pkt_v_o && tag_mem_pkt_yumi_i &&
                 (tag_mem_pkt_o.opcode == e_tag_set_clear) &&
                 (clears_seen == `PCE_SETS - 1), cache_req_complete_o);
      if (pce_l15_req_v_o) begin
        if (req_q.size() == 0) begin
          $display("Unexpected L1.5 request at time %0t", $time);
          fail_run();
        end else begin
          check_l15_req(req_q.pop_front(), pce_l15_req_o);
          reqs_seen++;
          credit_cnt++;
        end
      end
      if (l15_pce_ret_yumi_o && (credit_cnt > 0)) begin
        credit_cnt--;
      end
      if (data_mem_pkt_v_o && data_mem_pkt_yumi_i && pkt_take) begin
        if (data_q.size() == 0) begin
          $display("Unexpected data memory packet at time %0t", $time);
          fail_run();
        end else begin
          check_data_pkt(data_q.pop_front(), data_mem_pkt_o);
        end
      end
      if (tag_mem_pkt_v_o && tag_mem_pkt_yumi_i && pkt_take) begin
        if (tag_q.size() == 0) begin
          $display("Unexpected tag memory packet at time %0t", $time);
          fail_run();
        end else begin
          check_tag_pkt(tag_q.pop_front(), tag_mem_pkt_o);
          if (tag_mem_pkt_o.opcode == e_tag_set_clear) begin
            clears_seen++;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      fail_run();
    end
  end

  initial begin
    l15_ret_s ret;
    void'($urandom(51));
    reqs_seen       = 0;
    clears_seen     = 0;
    credit_cnt      = 0;
    cycle_cnt       = 0;
    engine_idle     = 1'b0;
    cache_req_i     = '0;
    cache_req_v_i   = 1'b0;
    cache_meta_i    = '0;
    cache_meta_v_i  = 1'b0;
    l15_pce_ret_i   = '0;
    l15_pce_ret_v_i = 1'b0;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("cache_req_ready_o", 1'b0, cache_req_ready_o);
    check_flag("pce_l15_req_v_o", 1'b0, pce_l15_req_v_o);
    check_flag("data_mem_pkt_v_o", 1'b0, data_mem_pkt_v_o);
    check_flag("tag_mem_pkt_v_o", 1'b0, tag_mem_pkt_v_o);
    check_flag("credits_empty_o", 1'b1, credits_empty_o);
    wait (!reset_i);
    next_cycle();

    // Start-up sweep
    for (int i = 0; i < `PCE_SETS; i++) begin
      tag_q.push_back(clear_tag_ref(index_t'(i)));
    end
    ret = '0;
    ret.rtntype = e_int_ret;
    send_ret(ret);
    while (clears_seen < `PCE_SETS) begin
      next_cycle();
    end
    engine_idle = 1'b1;

    // Stores in groups of four outstanding
    for (int g = 0; g < 6; g++) begin
      for (int k = 0; k < `PCE_MAX_CREDITS; k++) begin
        send_store();
      end
      @(negedge clk_i);
      check_flag("credits_full_o", 1'b1, credits_full_o);
      next_cycle();
      ret = '0;
      ret.rtntype = e_st_ack;
      for (int k = 0; k < `PCE_MAX_CREDITS; k++) begin
        send_ret(ret);
      end
    end

    for (int n = 0; n < 8; n++) begin
      run_load(1'b0, n[0]);
    end
    for (int n = 0; n < 8; n++) begin
      run_load(1'b1, (n % 3) == 0);
    end
    for (int n = 0; n < 4; n++) begin
      send_evict();
    end

    repeat (4) next_cycle();
    if ((req_q.size() == 0) && (data_q.size() == 0) && (tag_q.size() == 0)) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Missing transfers at the end: %0d requests, %0d data, %0d tag packets",
               req_q.size(), data_q.size(), tag_q.size());
      fail_run();
    end
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/pce_pkg.sv
hdl/pce_fsm.sv
hdl/pce_credit_counter.sv
hdl/pce_req_path.sv
hdl/pce_return_handler.sv
hdl/pce_top.sv
verif/pce_clock_gen.sv
verif/pce_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache engine testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" \
  && verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
       --top-module pce_tb -o pce_sim \
  && ./obj_dir/pce_sim | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
